//--- tb.f
hdl/graph_pkg.sv
hdl/node_id_mapper_dpram.sv
hdl/node_line_decoder.sv
hdl/node_id_mapper.sv
hdl/graph_ingest_top.sv
verification/graph_ingest_assertions.sv
verification/graph_ingest_checker.sv
verification/graph_ingest_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the graph ingest testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module graph_ingest_tb \
    -f tb.f -o graph_ingest_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/graph_ingest_sim +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -qx "TESTBENCH PASSED" && echo "run ok" && exit 0 \
    || { echo "run failed"; exit 1; }

//--- verification/graph_ingest_tb.sv
`timescale 1ns/1ps
`default_nettype none

module graph_ingest_tb;
    import graph_pkg::*;

    localparam int          CLK_HALF_NS   = 4;
    localparam int          RESET_CYCLES  = 5;
    localparam int          NUM_LINES     = 40;
    localparam int          DONE_TIMEOUT  = 200;
    localparam int          QUIET_CYCLES  = 20;
    localparam logic [31:0] LFSR_SEED     = 32'h4417;
    localparam logic [23:0] START_TEXT    = "you";
    localparam logic [23:0] END_TEXT      = "out";

    logic          clk;
    logic          rst_n;
    logic          text_valid;
    logic [7:0]    text_byte;
    logic          text_last;
    logic          edge_out_valid;
    indexed_edge_t edge_out;
    node_idx_t     node_count;
    node_idx_t     start_idx;
    node_idx_t     end_idx;
    logic          start_end_valid;
    logic          done;

    logic [31:0]   lfsr_state;
    logic [7:0]    text_q [$];
    int            name_map [logic [23:0]];
    int            timeout_errors;
    int            total_errors;

    graph_ingest_top graph_ingest_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .text_valid      (text_valid),
        .text_byte       (text_byte),
        .text_last       (text_last),
        .edge_out_valid  (edge_out_valid),
        .edge_out        (edge_out),
        .node_count      (node_count),
        .start_idx       (start_idx),
        .end_idx         (end_idx),
        .start_end_valid (start_end_valid),
        .done            (done)
    );

    graph_ingest_checker graph_ingest_checker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .edge_out_valid  (edge_out_valid),
        .edge_out        (edge_out),
        .node_count      (node_count),
        .start_idx       (start_idx),
        .end_idx         (end_idx),
        .start_end_valid (start_end_valid),
        .done            (done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF_NS clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit taken
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // letters a..d only, so names repeat often
    function automatic logic [23:0] pick_name();
        logic [23:0] name;
        name = '0;
        for (int i = 0; i < 3; i++) begin
            name = {name[15:0], 8'(8'h61 + rand_bits(2))};
        end
        return name;
    endfunction

    // reference model: dense index in order of first appearance
    function automatic int index_of_name(input logic [23:0] name);
        int next_index;
        next_index = name_map.num();
        if (!name_map.exists(name)) begin
            name_map[name] = next_index;
        end
        return name_map[name];
    endfunction

    task automatic append_name(input logic [23:0] name);
        text_q.push_back(name[23:16]);
        text_q.push_back(name[15:8]);
        text_q.push_back(name[7:0]);
    endtask

    // a middle line starts at "you", last line ends at "out"
    task automatic build_text();
        logic [23:0]   src;
        logic [23:0]   dst;
        int unsigned   n_dst;
        indexed_edge_t e;
        for (int line_no = 0; line_no < NUM_LINES; line_no++) begin
            src = (line_no == NUM_LINES / 2) ? START_TEXT : pick_name();
            append_name(src);
            e.src_idx = node_idx_t'(index_of_name(src));
            text_q.push_back(ASCII_COLON);
            n_dst = 1 + rand_bits(2);
            for (int d = 0; d < n_dst; d++) begin
                if ((line_no == NUM_LINES - 1) && (d == n_dst - 1)) begin
                    dst = END_TEXT;
                end else begin
                    dst = pick_name();
                end
                text_q.push_back(ASCII_SPACE);
                append_name(dst);
                e.dst_idx = node_idx_t'(index_of_name(dst));
                graph_ingest_checker_i.exp_edges.push_back(e);
            end
            text_q.push_back(ASCII_NEWLINE);
        end
    endtask

    // random idle gap of 0..3 cycles before each byte
    task automatic send_byte(input logic [7:0] b, input logic last);
        int unsigned gap;
        gap = rand_bits(2);
        repeat (gap) begin
            @(negedge clk);
            text_valid = 1'b0;
            text_last  = 1'b0;
        end
        @(negedge clk);
        text_valid = 1'b1;
        text_byte  = b;
        text_last  = last;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while ((graph_ingest_checker_i.done_count == 0) && (cycles < DONE_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
        end
        if (graph_ingest_checker_i.done_count == 0) begin
            timeout_errors++;
            $display("timeout: done did not pulse within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        text_valid     = 1'b0;
        text_byte      = 8'h00;
        text_last      = 1'b0;
        timeout_errors = 0;
        lfsr_state     = LFSR_SEED;

        build_text();
        graph_ingest_checker_i.exp_node_count = node_idx_t'(name_map.num());
        graph_ingest_checker_i.exp_start_idx  = node_idx_t'(name_map[START_TEXT]);
        graph_ingest_checker_i.exp_end_idx    = node_idx_t'(name_map[END_TEXT]);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < text_q.size(); i++) begin
            send_byte(text_q[i], i == text_q.size() - 1);
        end
        @(negedge clk);
        text_valid = 1'b0;
        text_last  = 1'b0;

        wait_for_done();
        // window to catch stray edges or a second done
        repeat (QUIET_CYCLES) @(negedge clk);

        total_errors = graph_ingest_checker_i.value_errors
                       + graph_ingest_checker_i.protocol_errors + timeout_errors
                       + int'(graph_ingest_top_i.node_id_mapper_i
                              .graph_ingest_assertions_i.fail_count);
        $display("error counts: values %0d, protocol %0d, timeouts %0d, assertions %0d",
                 graph_ingest_checker_i.value_errors,
                 graph_ingest_checker_i.protocol_errors, timeout_errors,
                 graph_ingest_top_i.node_id_mapper_i.graph_ingest_assertions_i.fail_count);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/graph_ingest_checker.sv
`timescale 1ns/1ps
`default_nettype none

module graph_ingest_checker (
    input wire                           clk,
    input wire                           rst_n,
    input wire                           edge_out_valid,
    input wire graph_pkg::indexed_edge_t edge_out,
    input wire graph_pkg::node_idx_t     node_count,
    input wire graph_pkg::node_idx_t     start_idx,
    input wire graph_pkg::node_idx_t     end_idx,
    input wire                           start_end_valid,
    input wire                           done
);
    import graph_pkg::*;

    // filled by the testbench before reset is released
    indexed_edge_t exp_edges [$];
    node_idx_t     exp_node_count;
    node_idx_t     exp_start_idx;
    node_idx_t     exp_end_idx;

    int value_errors    = 0;
    int protocol_errors = 0;
    int done_count      = 0;
    int edges_seen      = 0;

    task automatic match_edge();
        indexed_edge_t exp;
        if (done_count != 0) begin
            protocol_errors++;
            $display("edge arrived after done: src 0x%h dst 0x%h",
                     edge_out.src_idx, edge_out.dst_idx);
        end else if (exp_edges.size() == 0) begin
            protocol_errors++;
            $display("edge arrived when no more edges were expected");
        end else begin
            exp = exp_edges.pop_front();
            if (edge_out.src_idx !== exp.src_idx) begin
                value_errors++;
                $display("CHECK FAILED edge_out.src_idx: got 0x%h expected 0x%h (edge %0d)",
                         edge_out.src_idx, exp.src_idx, edges_seen);
            end
            if (edge_out.dst_idx !== exp.dst_idx) begin
                value_errors++;
                $display("CHECK FAILED edge_out.dst_idx: got 0x%h expected 0x%h (edge %0d)",
                         edge_out.dst_idx, exp.dst_idx, edges_seen);
            end
            // out only shows up in the final edge
            if ((exp_edges.size() != 0) && (start_end_valid !== 1'b0)) begin
                value_errors++;
                $display("CHECK FAILED start_end_valid: got 0x%h expected 0x0 (edge %0d)",
                         start_end_valid, edges_seen);
            end
            edges_seen++;
        end
    endtask

    task automatic audit_totals();
        done_count++;
        if (done_count > 1) begin
            protocol_errors++;
            $display("done pulsed more than once");
        end
        if (exp_edges.size() != 0) begin
            protocol_errors++;
            $display("done came with %0d expected edges still missing", exp_edges.size());
        end
        if (node_count !== exp_node_count) begin
            value_errors++;
            $display("CHECK FAILED node_count: got 0x%h expected 0x%h",
                     node_count, exp_node_count);
        end
        if (start_idx !== exp_start_idx) begin
            value_errors++;
            $display("CHECK FAILED start_idx: got 0x%h expected 0x%h", start_idx, exp_start_idx);
        end
        if (end_idx !== exp_end_idx) begin
            value_errors++;
            $display("CHECK FAILED end_idx: got 0x%h expected 0x%h", end_idx, exp_end_idx);
        end
        if (start_end_valid !== 1'b1) begin
            value_errors++;
            $display("CHECK FAILED start_end_valid: got 0x%h expected 0x1", start_end_valid);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (edge_out_valid || done || start_end_valid || (node_count != '0)) begin
                protocol_errors++;
                $display("outputs were not idle during reset");
            end
        end else begin
            // done first, so an edge in the same cycle counts as late
            if (done) begin
                audit_totals();
            end
            if (edge_out_valid) begin
                match_edge();
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/graph_ingest_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module graph_ingest_assertions (
    input wire clk,
    input wire rst_n,
    input wire edge_out_valid,
    input wire src_valid_q,
    input wire edge_valid_q,
    input wire done,
    input wire start_end_valid
);
    int unsigned fail_count = 0;

    // strobes are at least four cycles apart
    edge_gap_a: assert property (@(posedge clk) disable iff (!rst_n)
        edge_out_valid |=> !edge_out_valid)
        else begin
            $error("edge_out_valid high in two consecutive cycles");
            fail_count++;
        end

    strobe_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(src_valid_q && edge_valid_q))
        else begin
            $error("delayed source and edge strobes high together");
            fail_count++;
        end

    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |-> (!edge_out_valid && !done && !start_end_valid))
        else begin
            $error("mapper outputs active during reset");
            fail_count++;
        end

endmodule

bind node_id_mapper graph_ingest_assertions graph_ingest_assertions_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .edge_out_valid  (edge_out_valid),
    .src_valid_q     (src_valid_q),
    .edge_valid_q    (edge_valid_q),
    .done            (done),
    .start_end_valid (start_end_valid)
);

`default_nettype wire

//--- hdl/graph_ingest_top.sv
`timescale 1ns/1ps
`default_nettype none

module graph_ingest_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      text_valid,
    input  wire  [7:0]               text_byte,
    input  wire                      text_last,
    output logic                     edge_out_valid,
    output graph_pkg::indexed_edge_t edge_out,
    output graph_pkg::node_idx_t     node_count,
    output graph_pkg::node_idx_t     start_idx,
    output graph_pkg::node_idx_t     end_idx,
    output logic                     start_end_valid,
    output logic                     done
);
    import graph_pkg::*;

    logic       src_name_valid;
    node_name_u src_name;
    logic       edge_valid;
    node_name_u dst_name;
    logic       decoding_done;

    node_line_decoder node_line_decoder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .text_valid     (text_valid),
        .text_byte      (text_byte),
        .text_last      (text_last),
        .src_name_valid (src_name_valid),
        .src_name       (src_name),
        .edge_valid     (edge_valid),
        .dst_name       (dst_name),
        .decoding_done  (decoding_done)
    );

    node_id_mapper node_id_mapper_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .src_name_valid  (src_name_valid),
        .src_name        (src_name),
        .edge_valid      (edge_valid),
        .dst_name        (dst_name),
        .decoding_done   (decoding_done),
        .edge_out_valid  (edge_out_valid),
        .edge_out        (edge_out),
        .node_count      (node_count),
        .start_idx       (start_idx),
        .end_idx         (end_idx),
        .start_end_valid (start_end_valid),
        .done            (done)
    );

endmodule

`default_nettype wire

//--- hdl/node_id_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module node_id_mapper (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        src_name_valid,
    input  wire graph_pkg::node_name_u src_name,
    input  wire                        edge_valid,
    input  wire graph_pkg::node_name_u dst_name,
    input  wire                        decoding_done,
    output logic                       edge_out_valid,
    output graph_pkg::indexed_edge_t   edge_out,
    output graph_pkg::node_idx_t       node_count,
    output graph_pkg::node_idx_t       start_idx,
    output graph_pkg::node_idx_t       end_idx,
    output logic                       start_end_valid,
    output logic                       done
);
    import graph_pkg::*;

    logic       src_valid_q;
    logic       edge_valid_q;
    logic       done_q;
    node_name_u src_name_q;
    node_name_u dst_name_q;
    lut_entry_t src_rd_data;
    lut_entry_t dst_rd_data;
    logic       src_wr_en;
    logic       dst_wr_en;
    lut_entry_t wr_entry;
    node_idx_t  next_idx;
    node_idx_t  cur_src_idx;
    node_idx_t  src_resolved;
    node_idx_t  dst_resolved;
    logic       src_is_new;
    logic       dst_is_new;
    logic       res_valid;
    node_name_u res_name;
    node_idx_t  res_idx;
    logic       start_seen;
    logic       end_seen;

    // table is addressed straight from the decoder, data returns a cycle later
    node_id_mapper_dpram node_id_mapper_dpram_i (
        .clk         (clk),
        .src_addr    (src_name),
        .dst_addr    (dst_name),
        .src_wr_en   (src_wr_en),
        .dst_wr_en   (dst_wr_en),
        .src_wr_data (wr_entry),
        .dst_wr_data (wr_entry),
        .src_rd_data (src_rd_data),
        .dst_rd_data (dst_rd_data)
    );

    assign src_is_new   = src_valid_q && !src_rd_data.assigned;
    assign dst_is_new   = edge_valid_q && !dst_rd_data.assigned;
    assign src_resolved = src_rd_data.assigned ? src_rd_data.idx : next_idx;
    assign dst_resolved = dst_rd_data.assigned ? dst_rd_data.idx : next_idx;

    // strobes are exclusive, so one name resolves per cycle
    assign res_valid = src_valid_q || edge_valid_q;
    assign res_name  = src_valid_q ? src_name_q : dst_name_q;
    assign res_idx   = src_valid_q ? src_resolved : dst_resolved;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_valid_q    <= 1'b0;
            edge_valid_q   <= 1'b0;
            done_q         <= 1'b0;
            edge_out_valid <= 1'b0;
            done           <= 1'b0;
            src_wr_en      <= 1'b0;
            dst_wr_en      <= 1'b0;
            next_idx       <= '0;
            start_seen     <= 1'b0;
            end_seen       <= 1'b0;
        end else begin
            src_valid_q    <= src_name_valid;
            edge_valid_q   <= edge_valid;
            done_q         <= decoding_done;
            edge_out_valid <= edge_valid_q;
            done           <= done_q;
            src_wr_en      <= src_is_new;
            dst_wr_en      <= dst_is_new;
            if (src_is_new || dst_is_new) begin
                next_idx <= next_idx + 1'b1;
            end
            if (res_valid && (res_name.raw == START_NODE_NAME.raw)) begin
                start_seen <= 1'b1;
            end
            if (res_valid && (res_name.raw == END_NODE_NAME.raw)) begin
                end_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        src_name_q <= src_name;
        dst_name_q <= dst_name;
        // holds the index handed out in the previous cycle
        wr_entry   <= '{assigned: 1'b1, idx: next_idx};
        if (src_valid_q) begin
            cur_src_idx <= src_resolved;
        end
        if (edge_valid_q) begin
            edge_out <= '{src_idx: cur_src_idx, dst_idx: dst_resolved};
        end
        if (res_valid && (res_name.raw == START_NODE_NAME.raw)) begin
            start_idx <= res_idx;
        end
        if (res_valid && (res_name.raw == END_NODE_NAME.raw)) begin
            end_idx <= res_idx;
        end
    end

    assign node_count      = next_idx;
    assign start_end_valid = start_seen && end_seen;

endmodule

`default_nettype wire

//--- hdl/node_line_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module node_line_decoder (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   text_valid,
    input  wire  [7:0]            text_byte,
    input  wire                   text_last,
    output logic                  src_name_valid,
    output graph_pkg::node_name_u src_name,
    output logic                  edge_valid,
    output graph_pkg::node_name_u dst_name,
    output logic                  decoding_done
);
    import graph_pkg::*;

    // 0..2 letters collected, 3 means the field is full
    localparam logic [1:0] CNT_FULL = 2'd3;

    logic       is_letter;
    logic       is_colon;
    logic       is_space;
    logic       is_newline;
    logic       name_complete;
    logic [1:0] letter_cnt;
    logic       after_colon;
    node_name_u name_sr;
    node_name_u name_next;

    assign is_letter  = text_valid && (text_byte >= ASCII_LOWER_A)
                        && (text_byte <= ASCII_LOWER_Z);
    assign is_colon   = text_valid && (text_byte == ASCII_COLON);
    assign is_space   = text_valid && (text_byte == ASCII_SPACE);
    assign is_newline = text_valid && (text_byte == ASCII_NEWLINE);

    // third letter of a field closes the name
    assign name_complete = is_letter && (letter_cnt == 2'd2);

    // new letter enters at lo, older ones move up
    always_comb begin
        name_next.letters.hi  = name_sr.letters.mid;
        name_next.letters.mid = name_sr.letters.lo;
        name_next.letters.lo  = to_letter(text_byte);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            letter_cnt     <= '0;
            after_colon    <= 1'b0;
            src_name_valid <= 1'b0;
            edge_valid     <= 1'b0;
            decoding_done  <= 1'b0;
        end else begin
            src_name_valid <= name_complete && !after_colon;
            edge_valid     <= name_complete && after_colon;
            decoding_done  <= text_valid && text_last;

            if (is_letter && (letter_cnt != CNT_FULL)) begin
                letter_cnt <= letter_cnt + 2'd1;
            end else if (is_space || is_colon || is_newline) begin
                letter_cnt <= '0;
            end

            // destinations follow the colon until end of line
            if (is_colon) begin
                after_colon <= 1'b1;
            end else if (is_newline) begin
                after_colon <= 1'b0;
            end
        end
    end

    // names stay put until the next strobe of the same kind
    always_ff @(posedge clk) begin
        if (is_letter && (letter_cnt != CNT_FULL)) begin
            name_sr <= name_next;
        end
        if (name_complete && !after_colon) begin
            src_name <= name_next;
        end
        if (name_complete && after_colon) begin
            dst_name <= name_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/node_id_mapper_dpram.sv
`timescale 1ns/1ps
`default_nettype none

module node_id_mapper_dpram (
    input  wire                        clk,
    input  wire graph_pkg::node_name_u src_addr,
    input  wire graph_pkg::node_name_u dst_addr,
    input  wire                        src_wr_en,
    input  wire                        dst_wr_en,
    input  wire graph_pkg::lut_entry_t src_wr_data,
    input  wire graph_pkg::lut_entry_t dst_wr_data,
    output graph_pkg::lut_entry_t      src_rd_data,
    output graph_pkg::lut_entry_t      dst_rd_data
);
    import graph_pkg::*;

    localparam int DEPTH = 2**NODE_STR_WIDTH;

    // one entry per possible three-letter name
    lut_entry_t lut [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            lut[i].assigned = 1'b0;
        end
    end

    // read returns old contents on a same-cycle write
    always @(posedge clk) begin
        if (src_wr_en) begin
            lut[src_addr.raw] <= src_wr_data;
        end
        if (dst_wr_en) begin
            lut[dst_addr.raw] <= dst_wr_data;
        end
        src_rd_data <= lut[src_addr.raw];
        dst_rd_data <= lut[dst_addr.raw];
    end

endmodule

`default_nettype wire

//--- hdl/graph_pkg.sv
`default_nettype none

package graph_pkg;

    // name key and table sizes
    localparam int NODE_STR_WIDTH = 15;
    localparam int MAX_NODES      = 1024;
    localparam int NODE_IDX_WIDTH = $clog2(MAX_NODES);
    localparam int LETTER_WIDTH   = 5;

    // ascii codes seen by the line decoder
    localparam logic [7:0] ASCII_LOWER_A = 8'h61;
    localparam logic [7:0] ASCII_LOWER_Z = 8'h7a;
    localparam logic [7:0] ASCII_COLON   = 8'h3a;
    localparam logic [7:0] ASCII_SPACE   = 8'h20;
    localparam logic [7:0] ASCII_NEWLINE = 8'h0a;

    // first character of a name sits in hi
    typedef struct packed {
        logic [LETTER_WIDTH-1:0] hi;
        logic [LETTER_WIDTH-1:0] mid;
        logic [LETTER_WIDTH-1:0] lo;
    } node_letters_t;

    typedef union packed {
        logic [NODE_STR_WIDTH-1:0] raw;
        node_letters_t             letters;
    } node_name_u;

    typedef logic [NODE_IDX_WIDTH-1:0] node_idx_t;

    typedef struct packed {
        logic      assigned;
        node_idx_t idx;
    } lut_entry_t;

    typedef struct packed {
        node_idx_t src_idx;
        node_idx_t dst_idx;
    } indexed_edge_t;

    function automatic logic [LETTER_WIDTH-1:0] to_letter(input logic [7:0] c);
        return LETTER_WIDTH'(c - ASCII_LOWER_A);
    endfunction

    localparam node_name_u START_NODE_NAME = {to_letter("y"), to_letter("o"), to_letter("u")};
    localparam node_name_u END_NODE_NAME   = {to_letter("o"), to_letter("u"), to_letter("t")};

endpackage

`default_nettype wire
